// ==== design/mdu_iq_pkg.sv ====
package mdu_iq_pkg;

    localparam int IQ_DEPTH       = 4;
    localparam int NUM_WAKEUP     = 4;
    localparam int PIPE_MDU       = 3;  // Multiply/divide bit of the dispatch pipe vector
    localparam int FUNCT3_DIV_BIT = 2;  // Set for div, divu, rem, remu

    typedef logic [5:0] preg_t;
    typedef logic [4:0] iid_t;
    typedef logic [6:0] opcode_t;
    typedef logic [6:0] funct7_t;
    typedef logic [2:0] funct3_t;
    typedef logic [4:0] pipe_t;
    typedef logic [1:0] age_t;
    typedef logic [2:0] count_t;
    typedef logic [IQ_DEPTH-1:0] entry_mask_t;

    // Micro-op as held in an entry and sent to the pipe
    typedef struct packed {
        iid_t    iid;
        opcode_t opcode;
        funct7_t funct7;
        funct3_t funct3;
        logic    psrc1_vld;
        preg_t   psrc1;
        logic    psrc2_vld;
        preg_t   psrc2;
        logic    pdst_vld;
        preg_t   pdst;
    } uop_t;

    typedef struct packed {
        uop_t uop;
        logic psrc1_ready;
        logic psrc2_ready;
    } dispatch_t;

    typedef struct packed {
        logic  vld;
        preg_t preg;
    } wakeup_t;

    typedef age_t    [IQ_DEPTH-1:0]   age_vec_t;
    typedef wakeup_t [NUM_WAKEUP-1:0] wakeup_vec_t;
    typedef uop_t    [IQ_DEPTH-1:0]   uop_vec_t;

endpackage

// ==== design/mdu_iq_entry.sv ====
module mdu_iq_entry (
    input  logic                    clk,
    input  logic                    rst_clk,
    input  logic                    flush,
    input  logic                    create_vld,
    input  mdu_iq_pkg::dispatch_t   dispatch,
    input  logic                    issue_sel,
    input  mdu_iq_pkg::wakeup_vec_t wakeup,
    output logic                    vld,
    output logic                    ready,
    output mdu_iq_pkg::uop_t        uop
);
    import mdu_iq_pkg::*;

    logic  src1_rdy;
    logic  src2_rdy;
    logic  src1_hit;
    logic  src2_hit;
    preg_t src1_preg;
    preg_t src2_preg;

    // Any wakeup channel carrying this register
    function automatic logic wakeup_match(input preg_t preg, input wakeup_vec_t wk);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_WAKEUP; i++)
        begin
            hit = hit | (wk[i].vld & (wk[i].preg == preg));
        end
        return hit;
    endfunction

    // During create the incoming sources are compared, later the stored ones
    assign src1_preg = create_vld ? dispatch.uop.psrc1 : uop.psrc1;
    assign src2_preg = create_vld ? dispatch.uop.psrc2 : uop.psrc2;

    assign src1_hit = wakeup_match(src1_preg, wakeup);
    assign src2_hit = wakeup_match(src2_preg, wakeup);

    always_ff @(posedge clk or negedge rst_clk)
    begin
        if (!rst_clk)
        begin
            vld      <= 1'b0;
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end
        else if (flush)
        begin
            vld <= 1'b0;
        end
        else if (create_vld)
        begin
            vld      <= 1'b1;
            // Unused source counts as ready
            src1_rdy <= ~dispatch.uop.psrc1_vld | dispatch.psrc1_ready | src1_hit;
            src2_rdy <= ~dispatch.uop.psrc2_vld | dispatch.psrc2_ready | src2_hit;
        end
        else
        begin
            if (issue_sel)
            begin
                vld <= 1'b0;
            end
            if (vld && src1_hit)
            begin
                src1_rdy <= 1'b1;
            end
            if (vld && src2_hit)
            begin
                src2_rdy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (create_vld)
        begin
            uop <= dispatch.uop;
        end
    end

    assign ready = vld & src1_rdy & src2_rdy;

endmodule

// ==== design/mdu_iq_age_ctrl.sv ====
module mdu_iq_age_ctrl (
    input  logic                    clk,
    input  logic                    rst_clk,
    input  logic                    flush,
    input  logic                    dispatch_vld,
    input  mdu_iq_pkg::pipe_t       dispatch_pipe,
    input  logic                    dispatch_stall,
    input  mdu_iq_pkg::entry_mask_t entry_vld,
    input  mdu_iq_pkg::entry_mask_t issue_sel,
    output logic                    full,
    output mdu_iq_pkg::entry_mask_t create_vld,
    output mdu_iq_pkg::age_vec_t    ages
);
    import mdu_iq_pkg::*;

    count_t      count;
    logic        create;
    logic        issue;
    entry_mask_t free_sel;
    age_t        issue_age;
    age_t        create_age;

    assign full   = (count == count_t'(IQ_DEPTH));
    assign create = dispatch_vld & dispatch_pipe[PIPE_MDU] & ~full & ~dispatch_stall;
    assign issue  = |issue_sel;

    // Lowest clear bit of the valid mask
    assign free_sel   = ~entry_vld & (entry_vld + entry_mask_t'(1));
    assign create_vld = free_sel & {IQ_DEPTH{create}};

    always_comb
    begin
        issue_age = '0;
        for (int i = 0; i < IQ_DEPTH; i++)
        begin
            issue_age = issue_age | (ages[i] & {$bits(age_t){issue_sel[i]}});
        end
    end

    // One slot frees up at the same edge when an issue goes out
    assign create_age = issue ? age_t'(count - count_t'(1)) : age_t'(count);

    always_ff @(posedge clk or negedge rst_clk)
    begin
        if (!rst_clk)
        begin
            count <= '0;
        end
        else if (flush)
        begin
            count <= '0;
        end
        else if (create && !issue)
        begin
            count <= count + count_t'(1);
        end
        else if (issue && !create)
        begin
            count <= count - count_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_clk)
    begin
        if (!rst_clk)
        begin
            ages <= '0;
        end
        else if (flush)
        begin
            ages <= '0;
        end
        else
        begin
            for (int i = 0; i < IQ_DEPTH; i++)
            begin
                if (create_vld[i])
                begin
                    ages[i] <= create_age;
                end
                else if (issue_sel[i])
                begin
                    ages[i] <= '0;
                end
                else if (issue && (ages[i] > issue_age))
                begin
                    ages[i] <= ages[i] - age_t'(1);  // Younger entries move up
                end
            end
        end
    end

endmodule

// ==== design/mdu_iq_select.sv ====
module mdu_iq_select (
    input  logic                    div_stall,
    input  mdu_iq_pkg::entry_mask_t entry_ready,
    input  mdu_iq_pkg::age_vec_t    ages,
    input  mdu_iq_pkg::uop_vec_t    entry_uop,
    output mdu_iq_pkg::entry_mask_t issue_sel,
    output logic                    issue_vld,
    output mdu_iq_pkg::uop_t        issue_uop
);
    import mdu_iq_pkg::*;

    localparam int KEY_W = $bits(age_t) + 1;

    entry_mask_t      issue_ok;
    logic [KEY_W-1:0] key [IQ_DEPTH];
    logic             pick_1;
    logic             pick_3;
    logic             pick_hi;
    logic [KEY_W-1:0] key_lo;
    logic [KEY_W-1:0] key_hi;
    logic [KEY_W-1:0] key_win;
    entry_mask_t      win_sel;

    // Divide class waits while the divider is busy
    always_comb
    begin
        for (int i = 0; i < IQ_DEPTH; i++)
        begin
            issue_ok[i] = entry_ready[i] & ~(div_stall & entry_uop[i].funct3[FUNCT3_DIV_BIT]);
            key[i]      = {~issue_ok[i], ages[i]};  // Ready and old sorts lowest
        end
    end

    // First level of the tree
    assign pick_1 = key[1] < key[0];
    assign pick_3 = key[3] < key[2];
    assign key_lo = pick_1 ? key[1] : key[0];
    assign key_hi = pick_3 ? key[3] : key[2];

    assign pick_hi = key_hi < key_lo;
    assign key_win = pick_hi ? key_hi : key_lo;

    assign win_sel = pick_hi ? {pick_3, ~pick_3, 2'b00} : {2'b00, pick_1, ~pick_1};

    assign issue_vld = ~key_win[KEY_W-1];
    assign issue_sel = win_sel & {IQ_DEPTH{issue_vld}};

    // AND-OR mux, all zero when nothing issues
    always_comb
    begin
        issue_uop = '0;
        for (int i = 0; i < IQ_DEPTH; i++)
        begin
            issue_uop = issue_uop | (entry_uop[i] & {$bits(uop_t){issue_sel[i]}});
        end
    end

endmodule

// ==== design/mdu_iq_top.sv ====
module mdu_iq_top (
    input  logic                    clk,
    input  logic                    rst_clk,
    input  logic                    flush,
    input  logic                    dispatch_vld,
    input  mdu_iq_pkg::pipe_t       dispatch_pipe,
    input  mdu_iq_pkg::dispatch_t   dispatch,
    input  logic                    dispatch_stall,
    input  logic                    div_stall,
    input  mdu_iq_pkg::wakeup_vec_t wakeup,
    output logic                    full,
    output logic                    issue_vld,
    output mdu_iq_pkg::uop_t        issue_uop
);
    import mdu_iq_pkg::*;

    entry_mask_t create_vld;
    entry_mask_t entry_vld;
    entry_mask_t entry_ready;
    entry_mask_t issue_sel;
    uop_vec_t    entry_uop;
    age_vec_t    ages;

    // Queue storage, one entry per slot
    for (genvar i = 0; i < IQ_DEPTH; i++)
    begin : g_entry
        mdu_iq_entry u_entry (
            .clk        (clk),
            .rst_clk    (rst_clk),
            .flush      (flush),
            .create_vld (create_vld[i]),
            .dispatch   (dispatch),
            .issue_sel  (issue_sel[i]),
            .wakeup     (wakeup),
            .vld        (entry_vld[i]),
            .ready      (entry_ready[i]),
            .uop        (entry_uop[i])
        );
    end

    mdu_iq_age_ctrl u_age_ctrl (
        .clk            (clk),
        .rst_clk        (rst_clk),
        .flush          (flush),
        .dispatch_vld   (dispatch_vld),
        .dispatch_pipe  (dispatch_pipe),
        .dispatch_stall (dispatch_stall),
        .entry_vld      (entry_vld),
        .issue_sel      (issue_sel),
        .full           (full),
        .create_vld     (create_vld),
        .ages           (ages)
    );

    // Oldest ready entry goes out in the same cycle
    mdu_iq_select u_select (
        .div_stall   (div_stall),
        .entry_ready (entry_ready),
        .ages        (ages),
        .entry_uop   (entry_uop),
        .issue_sel   (issue_sel),
        .issue_vld   (issue_vld),
        .issue_uop   (issue_uop)
    );

endmodule

// ==== tb/mdu_iq_tb.sv ====
module mdu_iq_tb;
    import mdu_iq_pkg::*;

    // One table row per clock cycle
    typedef struct packed {
        logic        flush;
        logic        dispatch_vld;
        pipe_t       dispatch_pipe;
        dispatch_t   dispatch;
        logic        dispatch_stall;
        logic        div_stall;
        wakeup_vec_t wakeup;
        logic        exp_full;
        logic        exp_vld;
        uop_t        exp_uop;
    } row_t;

    logic        clk;
    logic        rst_clk;
    logic        flush;
    logic        dispatch_vld;
    pipe_t       dispatch_pipe;
    dispatch_t   dispatch;
    logic        dispatch_stall;
    logic        div_stall;
    wakeup_vec_t wakeup;
    logic        full;
    logic        issue_vld;
    uop_t        issue_uop;

    row_t        rows [$];
    row_t        cur;
    logic [31:0] lfsr_state;
    iid_t        next_iid;
    preg_t       pool [9];  // Distinct register numbers

    mdu_iq_top DUT (
        .clk            (clk),
        .rst_clk        (rst_clk),
        .flush          (flush),
        .dispatch_vld   (dispatch_vld),
        .dispatch_pipe  (dispatch_pipe),
        .dispatch       (dispatch),
        .dispatch_stall (dispatch_stall),
        .div_stall      (div_stall),
        .wakeup         (wakeup),
        .full           (full),
        .issue_vld      (issue_vld),
        .issue_uop      (issue_uop)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst_clk = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_clk = 1'b1;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic rand_preg(output preg_t p);
        logic [31:0] v;
        rand_bits($bits(preg_t), v);
        p = preg_t'(v);
    endtask

    task automatic fill_pool();
        preg_t p;
        logic  dup;
        for (int i = 0; i < 9; i++)
        begin
            do
            begin
                rand_preg(p);
                dup = 1'b0;
                for (int j = 0; j < i; j++)
                begin
                    dup = dup | (pool[j] == p);
                end
            end while (dup);
            pool[i] = p;
        end
    endtask

    // M extension op with sequential iid and random destination
    task automatic new_uop(input funct3_t f3, input preg_t s1, input preg_t s2, output uop_t u);
        preg_t dst;
        rand_preg(dst);
        u           = '0;
        u.iid       = next_iid;
        u.opcode    = 7'h33;
        u.funct7    = 7'h01;
        u.funct3    = f3;
        u.psrc1_vld = 1'b1;
        u.psrc1     = s1;
        u.psrc2_vld = 1'b1;
        u.psrc2     = s2;
        u.pdst_vld  = 1'b1;
        u.pdst      = dst;
        next_iid    = next_iid + iid_t'(1);
    endtask

    task automatic start_row(input logic exp_full, input logic exp_vld, input uop_t exp_uop);
        cur          = '0;
        cur.exp_full = exp_full;
        cur.exp_vld  = exp_vld;
        cur.exp_uop  = exp_uop;
    endtask

    task automatic push_row();
        rows.push_back(cur);
    endtask

    task automatic idle_row(input logic exp_full, input logic exp_vld, input uop_t exp_uop);
        start_row(exp_full, exp_vld, exp_uop);
        push_row();
    endtask

    task automatic set_dispatch(input uop_t u, input logic r1, input logic r2);
        cur.dispatch_vld         = 1'b1;
        cur.dispatch_pipe        = pipe_t'(1 << PIPE_MDU);
        cur.dispatch.uop         = u;
        cur.dispatch.psrc1_ready = r1;
        cur.dispatch.psrc2_ready = r2;
    endtask

    task automatic set_wakeup(input int ch, input preg_t p);
        cur.wakeup[ch].vld  = 1'b1;
        cur.wakeup[ch].preg = p;
    endtask

    task automatic build_table();
        uop_t        u [6];
        preg_t       x;
        logic [31:0] v;
        fill_pool();
        rand_bits($bits(iid_t), v);
        next_iid = iid_t'(v);
        rand_preg(x);

        // Ready at dispatch, one issue in the next cycle
        new_uop(3'b000, x, x, u[0]);
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[0], 1'b1, 1'b1);
        push_row();
        idle_row(1'b0, 1'b1, u[0]);
        idle_row(1'b0, 1'b0, '0);

        new_uop(3'b001, x, x, u[1]);
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[1], 1'b1, 1'b1);
        cur.dispatch_pipe = 5'b00001;  // ALU pipe only
        push_row();
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[1], 1'b1, 1'b1);
        cur.dispatch_stall = 1'b1;
        push_row();
        idle_row(1'b0, 1'b0, '0);
        idle_row(1'b0, 1'b0, '0);

        // Three waiters on pool[0], one of them with no second operand
        new_uop(3'b000, pool[0], x, u[0]);
        new_uop(3'b001, pool[0], x, u[1]);
        u[1].psrc2_vld = 1'b0;
        new_uop(3'b011, pool[0], x, u[2]);
        for (int i = 0; i < 3; i++)
        begin
            start_row(1'b0, 1'b0, '0);
            set_dispatch(u[i], 1'b0, i != 1);
            push_row();
        end
        start_row(1'b0, 1'b0, '0);
        set_wakeup(2, pool[0]);
        push_row();
        for (int i = 0; i < 3; i++)
        begin
            idle_row(1'b0, 1'b1, u[i]);
        end
        idle_row(1'b0, 1'b0, '0);

        // Wait on psrc2, then a wakeup in the creation cycle
        rand_preg(x);
        new_uop(3'b000, x, pool[1], u[0]);
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[0], 1'b1, 1'b0);
        push_row();
        start_row(1'b0, 1'b0, '0);
        set_wakeup(1, pool[2]);
        push_row();
        idle_row(1'b0, 1'b0, '0);
        new_uop(3'b010, pool[1], x, u[1]);
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[1], 1'b0, 1'b1);
        set_wakeup(0, pool[1]);
        push_row();
        idle_row(1'b0, 1'b1, u[0]);
        idle_row(1'b0, 1'b1, u[1]);
        idle_row(1'b0, 1'b0, '0);

        new_uop(3'b100, x, x, u[0]);  // div
        new_uop(3'b000, x, x, u[1]);  // mul
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[0], 1'b1, 1'b1);
        cur.div_stall = 1'b1;
        push_row();
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[1], 1'b1, 1'b1);
        cur.div_stall = 1'b1;
        push_row();
        start_row(1'b0, 1'b1, u[1]);
        cur.div_stall = 1'b1;
        push_row();
        start_row(1'b0, 1'b0, '0);
        cur.div_stall = 1'b1;
        push_row();
        idle_row(1'b0, 1'b1, u[0]);
        idle_row(1'b0, 1'b0, '0);

        // Fill the queue with waiters on pool[3] to pool[6]
        for (int i = 0; i < 4; i++)
        begin
            rand_preg(x);
            new_uop(3'b001, pool[3+i], x, u[i]);
            start_row(1'b0, 1'b0, '0);
            set_dispatch(u[i], 1'b0, 1'b1);
            push_row();
        end
        new_uop(3'b000, x, x, u[4]);
        start_row(1'b1, 1'b0, '0);
        set_dispatch(u[4], 1'b1, 1'b1);  // Dropped while full
        push_row();
        start_row(1'b1, 1'b0, '0);
        set_wakeup(3, pool[4]);
        push_row();
        start_row(1'b1, 1'b1, u[1]);
        set_wakeup(0, pool[6]);
        push_row();
        new_uop(3'b000, pool[7], x, u[5]);
        start_row(1'b0, 1'b1, u[3]);
        set_dispatch(u[5], 1'b0, 1'b1);  // Takes rank two as slot three leaves
        set_wakeup(1, pool[3]);
        set_wakeup(2, pool[5]);
        push_row();
        idle_row(1'b0, 1'b1, u[0]);
        idle_row(1'b0, 1'b1, u[2]);
        new_uop(3'b000, x, x, u[1]);
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[1], 1'b1, 1'b1);
        set_wakeup(0, pool[7]);
        push_row();
        idle_row(1'b0, 1'b1, u[5]);
        idle_row(1'b0, 1'b1, u[1]);

        for (int i = 0; i < 4; i++)
        begin
            new_uop(3'b000, pool[8], x, u[i]);
            start_row(1'b0, 1'b0, '0);
            set_dispatch(u[i], 1'b0, 1'b1);
            push_row();
        end
        start_row(1'b1, 1'b0, '0);
        cur.flush = 1'b1;
        push_row();
        start_row(1'b0, 1'b0, '0);
        set_wakeup(1, pool[8]);
        push_row();
        idle_row(1'b0, 1'b0, '0);
        new_uop(3'b101, x, x, u[0]);
        start_row(1'b0, 1'b0, '0);
        set_dispatch(u[0], 1'b1, 1'b1);
        push_row();
        idle_row(1'b0, 1'b1, u[0]);
        idle_row(1'b0, 1'b0, '0);
    endtask

    task automatic drive_row(input row_t r);
        flush          = r.flush;
        dispatch_vld   = r.dispatch_vld;
        dispatch_pipe  = r.dispatch_pipe;
        dispatch       = r.dispatch;
        dispatch_stall = r.dispatch_stall;
        div_stall      = r.div_stall;
        wakeup         = r.wakeup;
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what, input int row);
        if (got !== exp)
        begin
            $display("mismatch at %0t: row %0d %s is %b, expected %b", $time, row, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "%s differs", what);
        end
    endtask

    task automatic check_uop(input uop_t got, input uop_t exp, input int row);
        if (got !== exp)
        begin
            $display("mismatch at %0t: row %0d issue_uop is %h, expected %h", $time, row, got, exp);
            $display("** FAIL **");
            $fatal(1, "issue_uop differs");
        end
    endtask

    initial
    begin
        int waited;
        flush          = 1'b0;
        dispatch_vld   = 1'b0;
        dispatch_pipe  = '0;
        dispatch       = '0;
        dispatch_stall = 1'b0;
        div_stall      = 1'b0;
        wakeup         = '0;
        lfsr_state     = 32'hae5b_31d3;
        build_table();

        waited = 0;
        while (rst_clk !== 1'b1)
        begin
            @(posedge clk);
            waited++;
            if (waited > 10)
            begin
                $display("reset was not released within 10 cycles");
                $display("** FAIL **");
                $fatal(1, "reset timeout");
            end
        end

        for (int r = 0; r < rows.size(); r++)
        begin
            @(negedge clk);
            drive_row(rows[r]);
            #4;  // Just ahead of the rising edge
            check_bit(full, rows[r].exp_full, "full", r);
            check_bit(issue_vld, rows[r].exp_vld, "issue_vld", r);
            check_uop(issue_uop, rows[r].exp_uop, r);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/mdu_iq_pkg.sv
design/mdu_iq_entry.sv
design/mdu_iq_age_ctrl.sv
design/mdu_iq_select.sv
design/mdu_iq_top.sv
tb/mdu_iq_tb.sv
